/* Makefile */
# Verilator build and run for the branch target buffer testbench

VERILATOR ?= verilator
TOP ?= btb_predictor_tb
RTL_TOP ?= btb_predictor
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter hdl/%,$(SOURCES))
PASS_MSG := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the exit status of the binary
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/btb_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module btb_entry #(
	parameter int ENTRY_ID = 0
) (
	input  logic clock_bus_i,
	input  logic resetn_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] fetch_pc_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] lookup_pc_i,
	btb_table_if.entry tbl
);

	logic valid_q;
	logic [btb_pkg::BTB_AGE_W-1:0] age_q;
	logic [btb_pkg::BW_WORD_ADDR-1:0] tag_q;
	logic [btb_pkg::BW_WORD_ADDR-1:0] target_q;
	btb_pkg::ctr_state_e ctr_q;
	btb_pkg::ctr_state_e ctr_next;
	logic wr_sel;
	logic touch_sel;

	assign wr_sel = tbl.we[ENTRY_ID];
	assign touch_sel = tbl.touch[ENTRY_ID];

	// fetch port and stage-1 port compare against the same tag
	assign tbl.fetch_hit[ENTRY_ID] = valid_q && (tag_q == fetch_pc_i);
	assign tbl.lookup_hit[ENTRY_ID] = valid_q && (tag_q == lookup_pc_i);
	assign tbl.valid[ENTRY_ID] = valid_q;
	assign tbl.age[ENTRY_ID] = age_q;
	assign tbl.counter[ENTRY_ID] = ctr_q;
	assign tbl.target[ENTRY_ID] = target_q;

	// new entries start from the fall-through guess unless it just missed
	always_comb begin
		if (tbl.alloc) begin
			ctr_next = tbl.wr_counter_set ? btb_pkg::WEAK_T : btb_pkg::STRONG_NT;
		end else if (ctr_q >= btb_pkg::WEAK_T) begin
			ctr_next = tbl.wr_counter_set ? btb_pkg::ctr_state_e'(ctr_q - 2'd1)
				: btb_pkg::STRONG_T;
		end else begin
			ctr_next = tbl.wr_counter_set ? btb_pkg::ctr_state_e'(ctr_q + 2'd1)
				: btb_pkg::STRONG_NT;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid_q <= 1'b0;
			age_q <= '0;
		end else begin
			if (wr_sel) begin
				valid_q <= 1'b1;
			end
			// LRU stack: written or touched entry goes to the top,
			// everything younger than the reference slides down by one
			if (tbl.age_en) begin
				if (wr_sel || touch_sel) begin
					age_q <= '0;
				end else if (valid_q && (age_q < tbl.ref_age)) begin
					age_q <= age_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (wr_sel) begin
			tag_q <= tbl.wr_tag;
			target_q <= tbl.wr_target;
		end
		if (wr_sel || touch_sel) begin
			ctr_q <= ctr_next;
		end
	end

	a_age_range: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		valid_q |-> (age_q < btb_pkg::BTB_AGE_W'(btb_pkg::BTB_ENTRIES)))
		else $error("entry %0d age out of range", ENTRY_ID);

	a_we_touch_excl: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		!(wr_sel && touch_sel))
		else $error("entry %0d written and touched together", ENTRY_ID);

endmodule

`default_nettype wire

/* hdl/btb_pkg.sv */
`default_nettype none

package btb_pkg;

	// address widths, the core fetches whole words
	localparam int BW_WORD_ADDR = 24;
	// byte address is the word address with two zero bits below it
	localparam int BW_BYTE_ADDR = BW_WORD_ADDR + 2;

	// table geometry
	localparam int BTB_ENTRIES = 8;
	localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
	// one extra bit so the value BTB_ENTRIES fits, used as "age everything"
	localparam int BTB_AGE_W = BTB_IDX_W + 1;

	// two-bit saturating counter
	// taken is predicted at WEAK_T and above
	typedef enum logic [1:0] {
		STRONG_NT = 2'd0,
		WEAK_NT   = 2'd1,
		WEAK_T    = 2'd2,
		STRONG_T  = 2'd3
	} ctr_state_e;

	// top two bits of the seven-bit opcode
	typedef enum logic [1:0] {
		GRP_LOAD  = 2'b00,
		GRP_IMM   = 2'b01,
		GRP_STORE = 2'b10,
		// branches and jumps
		GRP_CTRL  = 2'b11
	} opcode_grp_e;

endpackage

`default_nettype wire

/* hdl/btb_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module btb_predictor (
	input  logic clock_bus_i,
	input  logic resetn_i,
	input  logic [6:0] stage_1_opcode_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] PC_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] jump_destination_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] stage_1_instruct_addr_i,
	input  logic mispredict_i,
	output logic [btb_pkg::BW_BYTE_ADDR-1:0] pc_o,
	output logic predict_taken_o
);

	btb_table_if tbl ();

	// decides when the table is written and which slot is affected
	btb_update_ctrl btb_update_ctrl_i (
		.clock_bus_i             (clock_bus_i),
		.resetn_i                (resetn_i),
		.stage_1_opcode_i        (stage_1_opcode_i),
		.stage_1_instruct_addr_i (stage_1_instruct_addr_i),
		.jump_destination_i      (jump_destination_i),
		.mispredict_i            (mispredict_i),
		.tbl                     (tbl.ctrl)
	);

	// fully associative storage, fetch PC and stage-1 address
	// are compared in every entry
	for (genvar g = 0; g < btb_pkg::BTB_ENTRIES; g++) begin : g_entry
		btb_entry #(
			.ENTRY_ID (g)
		) btb_entry_i (
			.clock_bus_i (clock_bus_i),
			.resetn_i    (resetn_i),
			.fetch_pc_i  (PC_i),
			.lookup_pc_i (stage_1_instruct_addr_i),
			.tbl         (tbl.entry)
		);
	end

	// combinational next-PC for fetch
	btb_select btb_select_i (
		.PC_i            (PC_i),
		.tbl             (tbl.sel),
		.pc_o            (pc_o),
		.predict_taken_o (predict_taken_o)
	);

endmodule

`default_nettype wire

/* hdl/btb_select.sv */
`timescale 1ns/1ps
`default_nettype none

module btb_select (
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] PC_i,
	btb_table_if.sel tbl,
	output logic [btb_pkg::BW_BYTE_ADDR-1:0] pc_o,
	output logic predict_taken_o
);

	logic hit_any;
	logic [btb_pkg::BTB_IDX_W-1:0] hit_idx;
	btb_pkg::ctr_state_e hit_ctr;
	logic [btb_pkg::BW_WORD_ADDR-1:0] hit_target;
	logic [btb_pkg::BW_WORD_ADDR-1:0] fall_through;
	logic taken;

	assign hit_any = |tbl.fetch_hit;

	always_comb begin
		hit_idx = '0;
		for (int i = btb_pkg::BTB_ENTRIES - 1; i >= 0; i--) begin
			if (tbl.fetch_hit[i]) begin
				hit_idx = btb_pkg::BTB_IDX_W'(i);
			end
		end
	end

	assign hit_ctr = tbl.counter[hit_idx];
	assign hit_target = tbl.target[hit_idx];

	// next sequential word
	assign fall_through = PC_i + btb_pkg::BW_WORD_ADDR'(1);

	assign taken = hit_any && (hit_ctr >= btb_pkg::WEAK_T);

	always_comb begin
		if (taken) begin
			pc_o = {hit_target, 2'b00};
		end else begin
			pc_o = {fall_through, 2'b00};
		end
	end

	assign predict_taken_o = taken;

	// tags are unique, so at most one entry can match the fetch PC
	a_fetch_onehot: assert final ($onehot0(tbl.fetch_hit))
		else $error("fetch_hit not one-hot: %h", tbl.fetch_hit);

endmodule

`default_nettype wire

/* hdl/btb_table_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface btb_table_if;

	// per-entry status, each entry drives its own element
	logic [btb_pkg::BTB_ENTRIES-1:0] fetch_hit;
	logic [btb_pkg::BTB_ENTRIES-1:0] lookup_hit;
	logic [btb_pkg::BTB_ENTRIES-1:0] valid;
	logic [btb_pkg::BTB_AGE_W-1:0] age [btb_pkg::BTB_ENTRIES];
	btb_pkg::ctr_state_e counter [btb_pkg::BTB_ENTRIES];
	logic [btb_pkg::BW_WORD_ADDR-1:0] target [btb_pkg::BTB_ENTRIES];

	// broadcasts from the update controller
	logic [btb_pkg::BTB_ENTRIES-1:0] we;
	logic [btb_pkg::BW_WORD_ADDR-1:0] wr_tag;
	logic [btb_pkg::BW_WORD_ADDR-1:0] wr_target;
	// carries mispredict for the resolving branch
	logic wr_counter_set;
	logic alloc;
	logic [btb_pkg::BTB_ENTRIES-1:0] touch;
	logic [btb_pkg::BTB_AGE_W-1:0] ref_age;
	logic age_en;

	modport ctrl (
		input lookup_hit, valid, age,
		output we, wr_tag, wr_target, wr_counter_set, alloc, touch, ref_age, age_en
	);

	modport entry (
		output fetch_hit, lookup_hit, valid, age, counter, target,
		input we, wr_tag, wr_target, wr_counter_set, alloc, touch, ref_age, age_en
	);

	modport sel (
		input fetch_hit, counter, target
	);

endinterface

`default_nettype wire

/* hdl/btb_update_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module btb_update_ctrl (
	input  logic clock_bus_i,
	input  logic resetn_i,
	input  logic [6:0] stage_1_opcode_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] stage_1_instruct_addr_i,
	input  logic [btb_pkg::BW_WORD_ADDR-1:0] jump_destination_i,
	input  logic mispredict_i,
	btb_table_if.ctrl tbl
);

	logic [btb_pkg::BW_WORD_ADDR-1:0] prev_addr_q;
	logic prev_valid_q;
	btb_pkg::opcode_grp_e op_grp;
	logic do_update;
	logic hit_any;
	logic free_any;
	logic [btb_pkg::BTB_IDX_W-1:0] hit_idx;
	logic [btb_pkg::BTB_IDX_W-1:0] free_idx;
	logic [btb_pkg::BTB_IDX_W-1:0] lru_idx;
	logic [btb_pkg::BTB_IDX_W-1:0] wr_idx;

	// stage-1 address history, one update per instruction in stage 1
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			prev_valid_q <= 1'b0;
		end else begin
			prev_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		prev_addr_q <= stage_1_instruct_addr_i;
	end

	assign op_grp = btb_pkg::opcode_grp_e'(stage_1_opcode_i[6:5]);
	assign do_update = (op_grp == btb_pkg::GRP_CTRL) && prev_valid_q
		&& (stage_1_instruct_addr_i != prev_addr_q);

	assign hit_any = |tbl.lookup_hit;
	assign free_any = ~&tbl.valid;

	// lowest index wins in every search below
	always_comb begin
		hit_idx = '0;
		for (int i = btb_pkg::BTB_ENTRIES - 1; i >= 0; i--) begin
			if (tbl.lookup_hit[i]) begin
				hit_idx = btb_pkg::BTB_IDX_W'(i);
			end
		end
	end

	always_comb begin
		free_idx = '0;
		for (int i = btb_pkg::BTB_ENTRIES - 1; i >= 0; i--) begin
			if (!tbl.valid[i]) begin
				free_idx = btb_pkg::BTB_IDX_W'(i);
			end
		end
	end

	// only meaningful once the table is full, ages are then a permutation
	always_comb begin
		lru_idx = '0;
		for (int i = btb_pkg::BTB_ENTRIES - 1; i >= 0; i--) begin
			if (tbl.age[i] == btb_pkg::BTB_AGE_W'(btb_pkg::BTB_ENTRIES - 1)) begin
				lru_idx = btb_pkg::BTB_IDX_W'(i);
			end
		end
	end

	assign wr_idx = free_any ? free_idx : lru_idx;

	always_comb begin
		for (int i = 0; i < btb_pkg::BTB_ENTRIES; i++) begin
			tbl.we[i] = do_update && !hit_any && (wr_idx == btb_pkg::BTB_IDX_W'(i));
			tbl.touch[i] = do_update && hit_any && (hit_idx == btb_pkg::BTB_IDX_W'(i));
		end
	end

	// age reference: hit age on a hit, everyone on a free slot,
	// everyone but the victim when full
	always_comb begin
		if (hit_any) begin
			tbl.ref_age = tbl.age[hit_idx];
		end else if (free_any) begin
			tbl.ref_age = btb_pkg::BTB_AGE_W'(btb_pkg::BTB_ENTRIES);
		end else begin
			tbl.ref_age = btb_pkg::BTB_AGE_W'(btb_pkg::BTB_ENTRIES - 1);
		end
	end

	assign tbl.age_en = do_update;
	assign tbl.alloc = do_update && !hit_any;
	assign tbl.wr_tag = stage_1_instruct_addr_i;
	assign tbl.wr_target = jump_destination_i;
	assign tbl.wr_counter_set = mispredict_i;

	a_we_onehot: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		$onehot0(tbl.we))
		else $error("we not one-hot: %h", tbl.we);

	a_touch_onehot: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		$onehot0(tbl.touch))
		else $error("touch not one-hot: %h", tbl.touch);

	a_hit_no_write: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		hit_any |-> (tbl.we == '0))
		else $error("write issued while stage-1 address hits");

endmodule

`default_nettype wire

/* project.f */
hdl/btb_pkg.sv
hdl/btb_table_if.sv
hdl/btb_entry.sv
hdl/btb_update_ctrl.sv
hdl/btb_select.sv
hdl/btb_predictor.sv
sim/btb_predictor_tb.sv

/* sim/btb_predictor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module btb_predictor_tb;

	logic clock_bus_i;
	logic resetn_i;
	logic [6:0] stage_1_opcode_i;
	logic [btb_pkg::BW_WORD_ADDR-1:0] PC_i;
	logic [btb_pkg::BW_WORD_ADDR-1:0] jump_destination_i;
	logic [btb_pkg::BW_WORD_ADDR-1:0] stage_1_instruct_addr_i;
	logic mispredict_i;
	logic [btb_pkg::BW_BYTE_ADDR-1:0] pc_o;
	logic predict_taken_o;

	// reference model with the most recently used entry at the queue front
	logic [btb_pkg::BW_WORD_ADDR-1:0] m_tag [$];
	logic [btb_pkg::BW_WORD_ADDR-1:0] m_target [$];
	int m_ctr [$];
	logic m_prev_valid;
	logic [btb_pkg::BW_WORD_ADDR-1:0] m_prev_addr;
	logic [btb_pkg::BW_BYTE_ADDR-1:0] exp_pc;
	logic exp_taken;

	int seed;
	int cycle_cnt;
	logic timed_out;
	int error_count;
	int check_count;
	int test_num;
	int test_errors;
	int test_checks;
	logic [btb_pkg::BW_WORD_ADDR-1:0] lru_addr [9];
	logic [btb_pkg::BW_WORD_ADDR-1:0] rand_addr [12];

	initial begin
		clock_bus_i = 1'b0;
		cycle_cnt = 0;
		forever begin
			#5;
			clock_bus_i = ~clock_bus_i;
			if (clock_bus_i) begin
				cycle_cnt++;
			end
		end
	end

	btb_predictor btb_predictor_i (
		.clock_bus_i             (clock_bus_i),
		.resetn_i                (resetn_i),
		.stage_1_opcode_i        (stage_1_opcode_i),
		.PC_i                    (PC_i),
		.jump_destination_i      (jump_destination_i),
		.stage_1_instruct_addr_i (stage_1_instruct_addr_i),
		.mispredict_i            (mispredict_i),
		.pc_o                    (pc_o),
		.predict_taken_o         (predict_taken_o)
	);

	// outputs must still match the model when the edge samples them
	a_edge_pc: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		pc_o == exp_pc)
		else begin
			$display("error pc_o at edge: got %h, expected %h",
				$sampled(pc_o), $sampled(exp_pc));
			error_count++;
		end

	a_edge_taken: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		predict_taken_o == exp_taken)
		else begin
			$display("error predict_taken_o at edge: got %h, expected %h",
				$sampled(predict_taken_o), $sampled(exp_taken));
			error_count++;
		end

	function automatic int find_entry(input logic [btb_pkg::BW_WORD_ADDR-1:0] addr);
		int pos;
		pos = -1;
		foreach (m_tag[i]) begin
			if (m_tag[i] == addr && pos < 0) begin
				pos = i;
			end
		end
		return pos;
	endfunction

	function automatic int next_counter(input int ctr, input logic mis);
		int nxt;
		if (ctr >= int'(btb_pkg::WEAK_T)) begin
			nxt = mis ? ctr - 1 : int'(btb_pkg::STRONG_T);
		end else begin
			nxt = mis ? ctr + 1 : int'(btb_pkg::STRONG_NT);
		end
		return nxt;
	endfunction

	function automatic logic [btb_pkg::BW_WORD_ADDR-1:0] random_addr();
		logic [31:0] raw;
		raw = $random(seed);
		return raw[btb_pkg::BW_WORD_ADDR-1:0];
	endfunction

	function automatic logic [btb_pkg::BW_WORD_ADDR-1:0] dest_for(
		input logic [btb_pkg::BW_WORD_ADDR-1:0] addr);
		return addr ^ 24'h0F0F00;
	endfunction

	task automatic model_predict(input logic [btb_pkg::BW_WORD_ADDR-1:0] pc);
		int pos;
		pos = find_entry(pc);
		if (pos >= 0 && m_ctr[pos] >= int'(btb_pkg::WEAK_T)) begin
			exp_pc = {m_target[pos], 2'b00};
			exp_taken = 1'b1;
		end else begin
			exp_pc = {pc + btb_pkg::BW_WORD_ADDR'(1), 2'b00};
			exp_taken = 1'b0;
		end
	endtask

	// a hit keeps its target, a miss allocates or evicts the back of the queue
	task automatic model_update(input logic [btb_pkg::BW_WORD_ADDR-1:0] addr,
		input logic [btb_pkg::BW_WORD_ADDR-1:0] dest, input logic mis);
		int pos;
		int ctr;
		logic [btb_pkg::BW_WORD_ADDR-1:0] tgt;
		pos = find_entry(addr);
		if (pos >= 0) begin
			ctr = next_counter(m_ctr[pos], mis);
			tgt = m_target[pos];
			m_tag.delete(pos);
			m_target.delete(pos);
			m_ctr.delete(pos);
		end else begin
			ctr = mis ? int'(btb_pkg::WEAK_T) : int'(btb_pkg::STRONG_NT);
			tgt = dest;
			if (m_tag.size() == btb_pkg::BTB_ENTRIES) begin
				void'(m_tag.pop_back());
				void'(m_target.pop_back());
				void'(m_ctr.pop_back());
			end
		end
		m_tag.push_front(addr);
		m_target.push_front(tgt);
		m_ctr.push_front(ctr);
	endtask

	task automatic wait_cycle();
		int start;
		int guard;
		start = cycle_cnt;
		guard = 0;
		if (!timed_out) begin
			while (cycle_cnt == start && guard < 20) begin
				#2;
				guard++;
			end
			if (cycle_cnt == start) begin
				$display("timeout: no rising clock edge within %0d ns", 2 * guard);
				timed_out = 1'b1;
				error_count++;
			end
		end
	endtask

	// inputs change 1 ns after the edge, outputs are checked 2 ns later
	task automatic drive_cycle(input logic [btb_pkg::BW_WORD_ADDR-1:0] pc,
		input logic [6:0] opcode, input logic [btb_pkg::BW_WORD_ADDR-1:0] addr,
		input logic [btb_pkg::BW_WORD_ADDR-1:0] dest, input logic mis);
		logic in_reset;
		logic upd;
		PC_i = pc;
		stage_1_opcode_i = opcode;
		stage_1_instruct_addr_i = addr;
		jump_destination_i = dest;
		mispredict_i = mis;
		in_reset = !resetn_i;
		#2;
		model_predict(pc);
		if (!in_reset) begin
			check_count++;
			assert (pc_o === exp_pc) else begin
				$display("error pc_o: got %h, expected %h", pc_o, exp_pc);
				error_count++;
			end
			assert (predict_taken_o === exp_taken) else begin
				$display("error predict_taken_o: got %h, expected %h",
					predict_taken_o, exp_taken);
				error_count++;
			end
		end
		upd = !in_reset && (opcode[6:5] == btb_pkg::GRP_CTRL) && m_prev_valid
			&& (addr != m_prev_addr);
		wait_cycle();
		if (in_reset) begin
			m_tag.delete();
			m_target.delete();
			m_ctr.delete();
			m_prev_valid = 1'b0;
		end else begin
			if (upd) begin
				model_update(addr, dest, mis);
			end
			m_prev_valid = 1'b1;
		end
		m_prev_addr = addr;
	endtask

	task automatic lookup(input logic [btb_pkg::BW_WORD_ADDR-1:0] pc);
		drive_cycle(pc, {btb_pkg::GRP_LOAD, 5'b00011}, 24'hABCDE0, '0, 1'b0);
	endtask

	task automatic resolve(input logic [btb_pkg::BW_WORD_ADDR-1:0] pc,
		input logic [btb_pkg::BW_WORD_ADDR-1:0] addr,
		input logic [btb_pkg::BW_WORD_ADDR-1:0] dest, input logic mis);
		drive_cycle(pc, {btb_pkg::GRP_CTRL, 5'b00011}, addr, dest, mis);
	endtask

	// direct check that does not go through the model
	task automatic expect_prediction(input logic [btb_pkg::BW_WORD_ADDR-1:0] pc,
		input logic taken, input logic [btb_pkg::BW_WORD_ADDR-1:0] dest);
		logic [btb_pkg::BW_BYTE_ADDR-1:0] want_pc;
		lookup(pc);
		want_pc = taken ? {dest, 2'b00} : {pc + btb_pkg::BW_WORD_ADDR'(1), 2'b00};
		check_count++;
		assert (predict_taken_o === taken) else begin
			$display("error predict_taken_o: got %h, expected %h", predict_taken_o, taken);
			error_count++;
		end
		assert (pc_o === want_pc) else begin
			$display("error pc_o: got %h, expected %h", pc_o, want_pc);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		int k;
		resetn_i = 1'b0;
		for (k = 0; k < 3; k++) begin
			lookup(random_addr());
		end
		resetn_i = 1'b1;
		// the first cycle after reset never writes the table
		lookup(random_addr());
	endtask

	task automatic begin_test(input int num);
		test_num = num;
		test_errors = error_count;
		test_checks = check_count;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			check_count - test_checks, error_count - test_errors);
	endtask

	initial begin
		int i;
		int k;
		int idx;
		logic [31:0] raw;
		logic [btb_pkg::BW_WORD_ADDR-1:0] pc;
		seed = 32'h3072;
		error_count = 0;
		check_count = 0;
		timed_out = 1'b0;
		exp_pc = '0;
		exp_taken = 1'b0;
		m_prev_valid = 1'b0;
		m_prev_addr = '0;
		resetn_i = 1'b0;
		stage_1_opcode_i = '0;
		PC_i = '0;
		jump_destination_i = '0;
		stage_1_instruct_addr_i = '0;
		mispredict_i = 1'b0;

		begin_test(1);
		apply_reset();
		for (i = 0; i < 10; i++) begin
			expect_prediction(random_addr(), 1'b0, '0);
		end
		end_test("reset fall-through");

		begin_test(2);
		resolve(24'h000040, 24'h000040, 24'h001200, 1'b1);
		expect_prediction(24'h000040, 1'b1, 24'h001200);
		resolve(24'h000080, 24'h000080, 24'h002400, 1'b0);
		expect_prediction(24'h000080, 1'b0, '0);
		end_test("allocation");

		begin_test(3);
		for (i = 0; i < 12; i++) begin
			raw = $random(seed);
			resolve(24'h0000C0, 24'h0000C0, 24'h003600, raw[0]);
			lookup(24'h0000C0);
		end
		end_test("counter training");

		// held address trains once, a store group never trains
		begin_test(4);
		for (k = 0; k < 4; k++) begin
			resolve(24'h000100, 24'h000100, 24'h004800, 1'b1);
		end
		expect_prediction(24'h000100, 1'b1, 24'h004800);
		for (k = 0; k < 3; k++) begin
			drive_cycle(24'h000140, {btb_pkg::GRP_STORE, 5'b00011}, 24'h000140,
				24'h005A00, 1'b1);
		end
		expect_prediction(24'h000140, 1'b0, '0);
		end_test("update suppression");

		begin_test(5);
		apply_reset();
		for (i = 0; i < 9; i++) begin
			lru_addr[i] = btb_pkg::BW_WORD_ADDR'(32'h010000 + i * 16);
		end
		for (i = 0; i < 8; i++) begin
			resolve(lru_addr[i], lru_addr[i], dest_for(lru_addr[i]), 1'b1);
		end
		resolve(lru_addr[0], lru_addr[0], dest_for(lru_addr[0]), 1'b0);
		resolve(lru_addr[8], lru_addr[8], dest_for(lru_addr[8]), 1'b1);
		expect_prediction(lru_addr[1], 1'b0, '0);
		expect_prediction(lru_addr[0], 1'b1, dest_for(lru_addr[0]));
		expect_prediction(lru_addr[8], 1'b1, dest_for(lru_addr[8]));
		for (i = 2; i < 8; i++) begin
			lookup(lru_addr[i]);
		end
		end_test("lru replacement");

		begin_test(6);
		for (k = 0; k < 12; k++) begin
			rand_addr[k] = btb_pkg::BW_WORD_ADDR'(32'h200000 + k * 8);
		end
		for (i = 0; i < 200; i++) begin
			raw = $random(seed);
			idx = int'(raw[7:0]) % 12;
			if (raw[9]) begin
				pc = rand_addr[int'(raw[15:12]) % 12];
			end else begin
				pc = random_addr();
			end
			resolve(pc, rand_addr[idx], dest_for(rand_addr[idx]), raw[8]);
		end
		for (k = 0; k < 12; k++) begin
			lookup(rand_addr[k]);
		end
		end_test("random resolutions");

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
